//--- common/xgmac_pkg.sv
package xgmac_pkg;

   localparam int xgmii_lanes = 8;            // Byte lanes per XGMII word

   // XGMII control characters, valid when the lane's control bit is set
   typedef enum logic [7:0] {
      ctrl_idle      = 8'h07,
      ctrl_start     = 8'hFB,
      ctrl_terminate = 8'hFD,
      ctrl_error     = 8'hFE
   } xgmii_ctrl_t;

   // One 64-bit stream beat
   typedef struct packed {
      logic [63:0] tdata;
      logic [7:0]  tkeep;                      // Contiguous from lane 0
      logic        tlast;
      logic        tuser;                      // Bad frame, receive side only
   } axis_beat_t;

   // One XGMII word, same layout for tx and rx
   typedef struct packed {
      logic [63:0] d;                          // txd or rxd
      logic [7:0]  c;                          // txc or rxc, one bit per lane
   } xgmii_word_t;

   // Fixed words built by the framer
   localparam xgmii_word_t xgmii_idle_word  = {{8{ctrl_idle}}, 8'hFF};
   localparam xgmii_word_t xgmii_start_word = {{7{ctrl_idle}}, ctrl_start, 8'hFF};
   localparam xgmii_word_t xgmii_term_word  = {{7{ctrl_idle}}, ctrl_terminate, 8'hFF};
   localparam xgmii_word_t xgmii_error_word = {{8{ctrl_error}}, 8'hFF};

endpackage

//--- common/axil_pkg.sv
package axil_pkg;

   typedef enum logic [1:0] {
      okay   = 2'b00,
      slverr = 2'b10
   } axi_resp_t;

   // Single-cycle register request from the bridge
   typedef struct packed {
      logic        cs;                         // One cycle per request
      logic        rnw;
      logic [7:0]  addr;                       // Byte address
      logic [31:0] wdata;
   } ipif_req_t;

   // Answer, one cycle after cs
   typedef struct packed {
      logic        rdack;
      logic        wrack;
      logic        error;
      logic [31:0] rdata;
   } ipif_rsp_t;

   // Register map
   localparam logic [7:0] reg_ctrl      = 8'h00;  // Bit 0 tx_enable, bit 1 rx_enable
   localparam logic [7:0] reg_ifg       = 8'h04;  // Min idle words between frames
   localparam logic [7:0] reg_tx_frames = 8'h08;
   localparam logic [7:0] reg_rx_frames = 8'h0C;
   localparam logic [7:0] reg_rx_errors = 8'h10;

   localparam logic [3:0] ifg_reset = 4'd1;

endpackage

//--- axi_ipif/axil_ipif_bridge.sv
module axil_ipif_bridge (
   input  logic                clk156,
   input  logic                rst_n,
   input  logic [31:0]         s_axi_awaddr,
   input  logic                s_axi_awvalid,
   output logic                s_axi_awready,
   input  logic [31:0]         s_axi_wdata,
   input  logic [3:0]          s_axi_wstrb,    // Ignored, full-word writes only
   input  logic                s_axi_wvalid,
   output logic                s_axi_wready,
   output axil_pkg::axi_resp_t s_axi_bresp,
   output logic                s_axi_bvalid,
   input  logic                s_axi_bready,
   input  logic [31:0]         s_axi_araddr,
   input  logic                s_axi_arvalid,
   output logic                s_axi_arready,
   output logic [31:0]         s_axi_rdata,
   output axil_pkg::axi_resp_t s_axi_rresp,
   output logic                s_axi_rvalid,
   input  logic                s_axi_rready,
   output axil_pkg::ipif_req_t req,
   input  axil_pkg::ipif_rsp_t rsp
);
   import axil_pkg::*;

   typedef enum logic [1:0] {idle, wait_ack, resp_write, resp_read} state_t;

   state_t    state;
   axi_resp_t resp_q;                          // Shared by B and R channels
   logic      wr_hs;
   logic      rd_hs;

   // Write needs address and data together; write wins a tie
   assign wr_hs = (state == idle) && s_axi_awvalid && s_axi_wvalid;
   assign rd_hs = (state == idle) && s_axi_arvalid && !(s_axi_awvalid && s_axi_wvalid);

   assign s_axi_awready = wr_hs;
   assign s_axi_wready  = wr_hs;
   assign s_axi_arready = rd_hs;
   assign s_axi_bvalid  = (state == resp_write);
   assign s_axi_rvalid  = (state == resp_read);
   assign s_axi_bresp   = resp_q;
   assign s_axi_rresp   = resp_q;

   always_ff @(posedge clk156) begin
      // Request payload, captured on handshake
      if (wr_hs || rd_hs) begin
         req.rnw   <= rd_hs;
         req.addr  <= wr_hs ? s_axi_awaddr[7:0] : s_axi_araddr[7:0];
         req.wdata <= s_axi_wdata;
      end
      if (rsp.wrack || rsp.rdack) begin
         resp_q      <= rsp.error ? slverr : okay;
         s_axi_rdata <= rsp.rdata;             // Don't care on writes
      end

      if (!rst_n) begin
         state  <= idle;
         req.cs <= 1'b0;
      end else begin
         req.cs <= wr_hs || rd_hs;             // Single-cycle strobe
         case (state)
            idle: begin
               if (wr_hs || rd_hs)
                  state <= wait_ack;
            end
            wait_ack: begin
               if (rsp.wrack)
                  state <= resp_write;
               else if (rsp.rdack)
                  state <= resp_read;
            end
            resp_write: begin
               if (s_axi_bready)
                  state <= idle;
            end
            resp_read: begin
               if (s_axi_rready)
                  state <= idle;
            end
            default: state <= idle;
         endcase
      end
   end

   // Responses hold until accepted
   a_bvalid_hold: assert property (@(posedge clk156) disable iff (!rst_n)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp));
   a_rvalid_hold: assert property (@(posedge clk156) disable iff (!rst_n)
      s_axi_rvalid && !s_axi_rready |=>
         s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rresp));

   // Only one request in flight
   a_no_req_in_wait: assert property (@(posedge clk156) disable iff (!rst_n)
      state == wait_ack |=> !req.cs);

endmodule

//--- xgmac/xgmac_regs.sv
module xgmac_regs (
   input  logic                clk156,
   input  logic                rst_n,
   input  axil_pkg::ipif_req_t req,
   output axil_pkg::ipif_rsp_t rsp,
   input  logic                tx_frame_done,
   input  logic                rx_frame_done,
   input  logic                rx_frame_bad,
   output logic                tx_enable,
   output logic                rx_enable,
   output logic [3:0]          ifg_words
);
   import axil_pkg::*;

   logic [31:0] tx_frames;
   logic [31:0] rx_frames;
   logic [31:0] rx_errors;
   logic [31:0] rd_data;
   logic        hit;                           // Address decodes
   logic        writable;

   // Address decode and read mux
   always_comb begin
      rd_data  = '0;
      hit      = 1'b1;
      writable = 1'b0;
      case (req.addr)
         reg_ctrl: begin
            rd_data[1:0] = {rx_enable, tx_enable};
            writable     = 1'b1;
         end
         reg_ifg: begin
            rd_data[3:0] = ifg_words;
            writable     = 1'b1;
         end
         reg_tx_frames: rd_data = tx_frames;
         reg_rx_frames: rd_data = rx_frames;
         reg_rx_errors: rd_data = rx_errors;
         default:       hit = 1'b0;
      endcase
   end

   always_ff @(posedge clk156) begin
      rsp.rdata <= rd_data;
      if (!rst_n) begin
         rsp.rdack <= 1'b0;
         rsp.wrack <= 1'b0;
         rsp.error <= 1'b0;
         tx_enable <= 1'b0;
         rx_enable <= 1'b0;
         ifg_words <= ifg_reset;
         tx_frames <= '0;
         rx_frames <= '0;
         rx_errors <= '0;
      end else begin
         rsp.rdack <= req.cs && req.rnw;
         rsp.wrack <= req.cs && !req.rnw;
         rsp.error <= req.cs && (!hit || (!req.rnw && !writable));  // Unmapped or RO write
         if (req.cs && !req.rnw) begin
            case (req.addr)
               reg_ctrl: {rx_enable, tx_enable} <= req.wdata[1:0];
               reg_ifg:  ifg_words <= req.wdata[3:0];
               default:  ;                     // Error already flagged
            endcase
         end
         if (tx_frame_done)
            tx_frames <= tx_frames + 32'd1;    // Wraps
         if (rx_frame_done)
            rx_frames <= rx_frames + 32'd1;
         if (rx_frame_bad)
            rx_errors <= rx_errors + 32'd1;
      end
   end

   // One ack of one kind per request, none otherwise
   a_one_ack: assert property (@(posedge clk156) disable iff (!rst_n)
      ((rsp.rdack || rsp.wrack) == $past(req.cs)) && !(rsp.rdack && rsp.wrack));

endmodule

//--- xgmac/xgmac_tx.sv
module xgmac_tx (
   input  logic                   clk156,
   input  logic                   rst_n,
   input  logic                   tx_enable,
   input  logic [3:0]             ifg_words,
   input  xgmac_pkg::axis_beat_t  tx_axis,
   input  logic                   tx_axis_tvalid,
   output logic                   tx_axis_tready,
   output xgmac_pkg::xgmii_word_t xgmii_tx,
   output logic                   tx_frame_done
);
   import xgmac_pkg::*;

   typedef enum logic [1:0] {idle, data, term, gap} state_t;

   state_t      state;
   state_t      state_d;
   axis_beat_t  beat_q;                        // One beat behind the wire
   xgmii_word_t word_d;
   xgmii_word_t last_wd;                       // Last beat with terminate
   logic [3:0]  n_keep;
   logic [3:0]  gap_cnt;
   logic [3:0]  gap_d;
   logic        done_d;
   logic        accept;

   assign tx_axis_tready = tx_enable &&
                           (state == idle || (state == data && !beat_q.tlast));
   assign accept = tx_axis_tvalid && tx_axis_tready;

   // Terminate goes right after the last valid lane, idle above it
   always_comb begin
      n_keep = '0;
      for (int i = 0; i < xgmii_lanes; i++)
         n_keep = n_keep + 4'(beat_q.tkeep[i]);
      last_wd = {beat_q.tdata, 8'h00};
      for (int i = 0; i < xgmii_lanes; i++) begin
         if (i == n_keep) begin
            last_wd.d[8*i +: 8] = ctrl_terminate;
            last_wd.c[i]        = 1'b1;
         end else if (i > n_keep) begin
            last_wd.d[8*i +: 8] = ctrl_idle;
            last_wd.c[i]        = 1'b1;
         end
      end
   end

   // Next state and next word
   always_comb begin
      state_d = state;
      word_d  = xgmii_idle_word;
      gap_d   = gap_cnt;
      done_d  = 1'b0;
      case (state)
         idle: begin
            if (accept) begin
               word_d  = xgmii_start_word;     // First beat follows next word
               state_d = data;
            end
         end
         data: begin
            if (beat_q.tlast) begin
               word_d = last_wd;
               if (&beat_q.tkeep) begin
                  state_d = term;              // No lane left for terminate
               end else begin
                  state_d = gap;
                  gap_d   = 4'd1;
                  done_d  = 1'b1;
               end
            end else if (accept) begin
               word_d = {beat_q.tdata, 8'h00};
            end else begin
               word_d = xgmii_error_word;      // Underrun, frame goes out bad
            end
         end
         term: begin
            word_d  = xgmii_term_word;
            state_d = gap;
            gap_d   = 4'd1;
            done_d  = 1'b1;
         end
         gap: begin
            if (gap_cnt >= ifg_words)
               state_d = idle;
            else
               gap_d = gap_cnt + 4'd1;
         end
         default: state_d = idle;
      endcase
   end

   always_ff @(posedge clk156) begin
      if (accept)
         beat_q <= tx_axis;
      if (!rst_n) begin
         state         <= idle;
         gap_cnt       <= '0;
         xgmii_tx      <= xgmii_idle_word;
         tx_frame_done <= 1'b0;
      end else begin
         state         <= state_d;
         gap_cnt       <= gap_d;
         xgmii_tx      <= word_d;
         tx_frame_done <= done_d;              // Same cycle as terminate on the wire
      end
   end

   a_no_ready_in_gap: assert property (@(posedge clk156) disable iff (!rst_n)
      (state == term || state == gap) |-> !tx_axis_tready);

endmodule

//--- xgmac/xgmac_rx.sv
module xgmac_rx (
   input  logic                   clk156,
   input  logic                   rst_n,
   input  logic                   rx_enable,
   input  xgmac_pkg::xgmii_word_t xgmii_rx,
   output xgmac_pkg::axis_beat_t  rx_axis,
   output logic                   rx_axis_tvalid,
   output logic                   rx_frame_done,
   output logic                   rx_frame_bad
);
   import xgmac_pkg::*;

   xgmii_word_t in_q;                          // Word being decoded
   logic        in_frame;
   logic        err_q;                         // Sticky for current frame
   logic        is_start;
   logic        next_term0;                    // Lookahead on the incoming word
   logic        term_found;
   logic [2:0]  term_lane;
   logic [7:0]  term_keep;
   logic        ctrl_bad;

   assign is_start   = in_q.c[0] && (in_q.d[7:0] == ctrl_start);
   assign next_term0 = xgmii_rx.c[0] && (xgmii_rx.d[7:0] == ctrl_terminate);
   assign term_keep  = (8'h01 << term_lane) - 8'h01;

   // Terminate lane and bad control characters
   always_comb begin
      term_found = 1'b0;
      term_lane  = '0;
      ctrl_bad   = 1'b0;
      for (int i = 0; i < xgmii_lanes; i++) begin
         if (in_q.c[i]) begin
            if (!term_found && in_q.d[8*i +: 8] == ctrl_terminate) begin
               term_found = 1'b1;
               term_lane  = 3'(i);
            end else if (!term_found || in_q.d[8*i +: 8] != ctrl_idle) begin
               ctrl_bad = 1'b1;                // Error char, stray control or junk after term
            end
         end else if (term_found) begin
            ctrl_bad = 1'b1;                   // Data above terminate
         end
      end
   end

   always_ff @(posedge clk156) begin
      in_q          <= xgmii_rx;
      rx_axis.tdata <= in_q.d;
      rx_axis.tkeep <= term_found ? term_keep : 8'hFF;
      rx_axis.tlast <= term_found || next_term0;
      rx_axis.tuser <= (err_q || ctrl_bad) && (term_found || next_term0);  // Last beat only
      if (!rst_n) begin
         in_frame       <= 1'b0;
         err_q          <= 1'b0;
         rx_axis_tvalid <= 1'b0;
         rx_frame_done  <= 1'b0;
         rx_frame_bad   <= 1'b0;
      end else begin
         rx_axis_tvalid <= 1'b0;
         rx_frame_done  <= 1'b0;
         rx_frame_bad   <= 1'b0;
         if (!in_frame) begin
            in_frame <= is_start && rx_enable; // Drop frames while disabled
            err_q    <= 1'b0;
         end else if (term_found) begin
            in_frame       <= 1'b0;
            rx_axis_tvalid <= (term_lane != 3'd0);  // Lane 0 term went out already
            rx_frame_done  <= 1'b1;
            rx_frame_bad   <= err_q || ctrl_bad;
         end else begin
            rx_axis_tvalid <= 1'b1;
            err_q          <= err_q || ctrl_bad;
         end
      end
   end

   a_keep_nonzero: assert property (@(posedge clk156) disable iff (!rst_n)
      rx_axis_tvalid |-> (rx_axis.tkeep != 8'h00));

endmodule

//--- source/axi_10g_mac.sv
module axi_10g_mac (
   input  logic                   clk156,
   input  logic                   rst_n,
   input  logic [31:0]            s_axi_awaddr,
   input  logic                   s_axi_awvalid,
   output logic                   s_axi_awready,
   input  logic [31:0]            s_axi_wdata,
   input  logic [3:0]             s_axi_wstrb,
   input  logic                   s_axi_wvalid,
   output logic                   s_axi_wready,
   output axil_pkg::axi_resp_t    s_axi_bresp,
   output logic                   s_axi_bvalid,
   input  logic                   s_axi_bready,
   input  logic [31:0]            s_axi_araddr,
   input  logic                   s_axi_arvalid,
   output logic                   s_axi_arready,
   output logic [31:0]            s_axi_rdata,
   output axil_pkg::axi_resp_t    s_axi_rresp,
   output logic                   s_axi_rvalid,
   input  logic                   s_axi_rready,
   input  xgmac_pkg::axis_beat_t  tx_axis,
   input  logic                   tx_axis_tvalid,
   output logic                   tx_axis_tready,
   output xgmac_pkg::axis_beat_t  rx_axis,
   output logic                   rx_axis_tvalid,
   output xgmac_pkg::xgmii_word_t xgmii_tx,
   input  xgmac_pkg::xgmii_word_t xgmii_rx
);
   import axil_pkg::*;

   ipif_req_t  req;
   ipif_rsp_t  rsp;
   logic       tx_enable;
   logic       rx_enable;
   logic [3:0] ifg_words;
   logic       tx_frame_done;
   logic       rx_frame_done;
   logic       rx_frame_bad;

   // AXI4-Lite to register strobes
   axil_ipif_bridge u_bridge (
      .clk156        (clk156),
      .rst_n         (rst_n),
      .s_axi_awaddr  (s_axi_awaddr),
      .s_axi_awvalid (s_axi_awvalid),
      .s_axi_awready (s_axi_awready),
      .s_axi_wdata   (s_axi_wdata),
      .s_axi_wstrb   (s_axi_wstrb),
      .s_axi_wvalid  (s_axi_wvalid),
      .s_axi_wready  (s_axi_wready),
      .s_axi_bresp   (s_axi_bresp),
      .s_axi_bvalid  (s_axi_bvalid),
      .s_axi_bready  (s_axi_bready),
      .s_axi_araddr  (s_axi_araddr),
      .s_axi_arvalid (s_axi_arvalid),
      .s_axi_arready (s_axi_arready),
      .s_axi_rdata   (s_axi_rdata),
      .s_axi_rresp   (s_axi_rresp),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .req           (req),
      .rsp           (rsp)
   );

   xgmac_regs u_regs (
      .clk156        (clk156),
      .rst_n         (rst_n),
      .req           (req),
      .rsp           (rsp),
      .tx_frame_done (tx_frame_done),
      .rx_frame_done (rx_frame_done),
      .rx_frame_bad  (rx_frame_bad),
      .tx_enable     (tx_enable),
      .rx_enable     (rx_enable),
      .ifg_words     (ifg_words)
   );

   xgmac_tx u_tx (
      .clk156         (clk156),
      .rst_n          (rst_n),
      .tx_enable      (tx_enable),
      .ifg_words      (ifg_words),
      .tx_axis        (tx_axis),
      .tx_axis_tvalid (tx_axis_tvalid),
      .tx_axis_tready (tx_axis_tready),
      .xgmii_tx       (xgmii_tx),
      .tx_frame_done  (tx_frame_done)
   );

   xgmac_rx u_rx (
      .clk156         (clk156),
      .rst_n          (rst_n),
      .rx_enable      (rx_enable),
      .xgmii_rx       (xgmii_rx),
      .rx_axis        (rx_axis),
      .rx_axis_tvalid (rx_axis_tvalid),
      .rx_frame_done  (rx_frame_done),
      .rx_frame_bad   (rx_frame_bad)
   );

endmodule

//--- tests/tb_axi_10g_mac_tasks.svh
// All tasks start and return on a falling edge

task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                         input axi_resp_t resp);
   int n;
   exp_resp      = resp;                       // Seen by a_bresp
   s_axi_awaddr  = {24'h0, addr};
   s_axi_wdata   = data;
   s_axi_awvalid = 1'b1;
   s_axi_wvalid  = 1'b1;
   s_axi_bready  = 1'b1;
   n = 0;
   while (!(s_axi_awready && s_axi_wready) && n < wait_limit) begin
      @(negedge clk156);
      n++;
   end
   if (!(s_axi_awready && s_axi_wready)) begin
      errors++;
      $display("timeout at %0t: write address and data %h never accepted together",
               $time, addr);
   end
   @(negedge clk156);                          // Handshake on the edge between
   s_axi_awvalid = 1'b0;
   s_axi_wvalid  = 1'b0;
   n = 0;
   while (!s_axi_bvalid && n < wait_limit) begin
      @(negedge clk156);
      n++;
   end
   if (!s_axi_bvalid) begin
      errors++;
      $display("timeout at %0t: no write response for address %h", $time, addr);
   end
   @(negedge clk156);
   s_axi_bready = 1'b0;
endtask

task automatic axi_read(input logic [7:0] addr, input logic [31:0] data,
                        input axi_resp_t resp, input bit chk);
   int n;
   exp_resp      = resp;
   exp_rdata     = data;
   check_rdata   = chk;                        // Off where rdata is don't care
   s_axi_araddr  = {24'h0, addr};
   s_axi_arvalid = 1'b1;
   s_axi_rready  = 1'b1;
   n = 0;
   while (!s_axi_arready && n < wait_limit) begin
      @(negedge clk156);
      n++;
   end
   if (!s_axi_arready) begin
      errors++;
      $display("timeout at %0t: read address %h never accepted", $time, addr);
   end
   @(negedge clk156);
   s_axi_arvalid = 1'b0;
   n = 0;
   while (!s_axi_rvalid && n < wait_limit) begin
      @(negedge clk156);
      n++;
   end
   if (!s_axi_rvalid) begin
      errors++;
      $display("timeout at %0t: no read data for address %h", $time, addr);
   end
   @(negedge clk156);
   s_axi_rready = 1'b0;
endtask

// Tvalid stays high from beat to beat so the framer never underruns
task automatic send_beat(input axis_beat_t b);
   int n;
   tx_axis        = b;
   tx_axis_tvalid = 1'b1;
   n = 0;
   while (!tx_axis_tready && n < wait_limit) begin
      @(negedge clk156);                       // Tready depends on state only
      n++;
   end
   if (!tx_axis_tready) begin
      errors++;
      $display("timeout at %0t: tx beat never accepted", $time);
   end
   @(negedge clk156);
endtask

task automatic send_frame(input int n_beats, input int last_lanes, input bit corrupt);
   axis_beat_t b;
   axis_beat_t e;
   for (int k = 0; k < n_beats; k++) begin
      b.tdata = {$urandom, $urandom};
      b.tlast = (k == n_beats - 1);
      b.tkeep = b.tlast ? (8'hFF >> (8 - last_lanes)) : 8'hFF;
      b.tuser = 1'b0;
      e       = b;
      if (corrupt) begin
         e.tuser = b.tlast;                    // Bad frame flagged on its last beat
         if (k == 0)
            e.tdata[7:0] = ctrl_error;         // Lane hit by the loopback
      end
      exp_q.push_back(e);
      send_beat(b);
   end
   tx_axis_tvalid = 1'b0;
endtask

task automatic wait_rx_drained();
   int n;
   n = 0;
   while (exp_q.size() != 0 && n < wait_limit) begin
      @(negedge clk156);
      n++;
   end
   if (exp_q.size() != 0) begin
      errors++;
      $display("timeout at %0t: %0d sent beats never came out of rx", $time, exp_q.size());
   end
endtask

task automatic end_test(input string name, input int errs_at_start);
   if (errors == errs_at_start) begin
      n_pass++;
      $display("test %s: ok", name);
   end else begin
      n_fail++;
      $display("test %s: failed with %0d errors", name, errors - errs_at_start);
   end
endtask

//--- tests/tb_axi_10g_mac.sv
module tb_axi_10g_mac;
   import xgmac_pkg::*;
   import axil_pkg::*;

   localparam int wait_limit = 500;            // Cycles per wait loop

   logic        clk156;
   logic        rst_n;
   logic [31:0] s_axi_awaddr;
   logic        s_axi_awvalid;
   logic        s_axi_awready;
   logic [31:0] s_axi_wdata;
   logic [3:0]  s_axi_wstrb;
   logic        s_axi_wvalid;
   logic        s_axi_wready;
   axi_resp_t   s_axi_bresp;
   logic        s_axi_bvalid;
   logic        s_axi_bready;
   logic [31:0] s_axi_araddr;
   logic        s_axi_arvalid;
   logic        s_axi_arready;
   logic [31:0] s_axi_rdata;
   axi_resp_t   s_axi_rresp;
   logic        s_axi_rvalid;
   logic        s_axi_rready;
   axis_beat_t  tx_axis;
   logic        tx_axis_tvalid;
   logic        tx_axis_tready;
   axis_beat_t  rx_axis;
   logic        rx_axis_tvalid;
   xgmii_word_t xgmii_tx;
   xgmii_word_t xgmii_rx;

   axis_beat_t  exp_q[$];                      // Beats sent and not yet received
   axi_resp_t   exp_resp;
   logic [31:0] exp_rdata;
   logic        check_rdata;
   logic        check_idle;                    // Tx must sit still
   logic        inject_err;
   logic        first_data;
   logic        beat_taken;
   int          errors;
   int          n_pass;
   int          n_fail;

   axi_10g_mac u_axi_10g_mac (.*);

   initial begin
      clk156 = 1'b0;
      forever #4 clk156 = ~clk156;
   end

   // Loopback with optional FE in lane 0 of a frame's first data word
   always @(posedge clk156)
      first_data <= rst_n && (xgmii_tx == xgmii_start_word);

   always_comb begin
      xgmii_rx = xgmii_tx;
      if (inject_err && first_data) begin
         xgmii_rx.d[7:0] = ctrl_error;
         xgmii_rx.c[0]   = 1'b1;
      end
   end

   // Queue head retires on the falling edge after its beat
   always @(posedge clk156)
      beat_taken <= rst_n && rx_axis_tvalid;
   always @(negedge clk156)
      if (beat_taken && exp_q.size() > 0)
         void'(exp_q.pop_front());

   function automatic bit rx_beat_ok(input axis_beat_t got);
      axis_beat_t  exp;
      logic [63:0] mask;
      if (exp_q.size() == 0)
         return 1'b0;
      exp = exp_q[0];
      for (int i = 0; i < xgmii_lanes; i++)
         mask[8*i +: 8] = {8{exp.tkeep[i]}};   // Only kept lanes carry data
      return ((got.tdata & mask) == (exp.tdata & mask)) && got.tkeep == exp.tkeep &&
             got.tlast == exp.tlast && got.tuser == exp.tuser;
   endfunction

   a_rx_beat: assert property (@(posedge clk156) disable iff (!rst_n)
      rx_axis_tvalid |-> rx_beat_ok(rx_axis))
      else begin
         errors++;
         if (exp_q.size() == 0)
            $display("rx beat arrived at %0t with no frame outstanding", $time);
         else
            $display("FAILED %0t rx_axis: got %h, expected %h", $time, rx_axis, exp_q[0]);
      end

   a_bresp: assert property (@(posedge clk156) disable iff (!rst_n)
      s_axi_bvalid |-> s_axi_bresp == exp_resp)
      else begin
         errors++;
         $display("FAILED %0t s_axi_bresp: got %h, expected %h", $time, s_axi_bresp, exp_resp);
      end

   a_rresp: assert property (@(posedge clk156) disable iff (!rst_n)
      s_axi_rvalid |-> s_axi_rresp == exp_resp)
      else begin
         errors++;
         $display("FAILED %0t s_axi_rresp: got %h, expected %h", $time, s_axi_rresp, exp_resp);
      end

   a_rdata: assert property (@(posedge clk156) disable iff (!rst_n)
      s_axi_rvalid && check_rdata |-> s_axi_rdata == exp_rdata)
      else begin
         errors++;
         $display("FAILED %0t s_axi_rdata: got %h, expected %h", $time, s_axi_rdata, exp_rdata);
      end

   a_tx_idle: assert property (@(posedge clk156) disable iff (!rst_n)
      check_idle |-> xgmii_tx == xgmii_idle_word)
      else begin
         errors++;
         $display("FAILED %0t xgmii_tx: got %h, expected %h", $time, xgmii_tx, xgmii_idle_word);
      end

   a_tready_low: assert property (@(posedge clk156) disable iff (!rst_n)
      check_idle |-> !tx_axis_tready)
      else begin
         errors++;
         $display("FAILED %0t tx_axis_tready: got 1, expected 0", $time);
      end

   `include "tb_axi_10g_mac_tasks.svh"

   initial begin
      int beats;
      int lanes;
      int start;
      void'($urandom(32'h1be91627));
      {s_axi_awaddr, s_axi_awvalid, s_axi_wdata, s_axi_wvalid, s_axi_bready} = '0;
      {s_axi_araddr, s_axi_arvalid, s_axi_rready} = '0;
      s_axi_wstrb    = 4'hF;
      tx_axis        = '0;
      tx_axis_tvalid = 1'b0;
      exp_resp       = okay;
      {exp_rdata, check_rdata, check_idle, inject_err} = '0;
      {errors, n_pass, n_fail} = '0;
      rst_n = 1'b0;
      repeat (16) @(negedge clk156);
      rst_n = 1'b1;
      @(negedge clk156);

      start      = errors;
      check_idle = 1'b1;
      axi_read(reg_ctrl, 32'd0, okay, 1'b1);
      axi_read(reg_ifg, 32'd1, okay, 1'b1);
      axi_read(reg_tx_frames, 32'd0, okay, 1'b1);
      axi_read(reg_rx_frames, 32'd0, okay, 1'b1);
      axi_read(reg_rx_errors, 32'd0, okay, 1'b1);
      check_idle = 1'b0;
      end_test("1 reset values", start);

      start = errors;
      axi_write(reg_ctrl, 32'h3, okay);
      for (int f = 0; f < 20; f++) begin
         beats = 1 + int'($urandom % 12);
         lanes = (f == 0) ? 8 : (f == 1) ? 3 : 1 + int'($urandom % 8);  // Both terminate forms
         send_frame(beats, lanes, 1'b0);
      end
      wait_rx_drained();
      end_test("2 random frames", start);

      start = errors;
      axi_read(reg_tx_frames, 32'd20, okay, 1'b1);
      axi_read(reg_rx_frames, 32'd20, okay, 1'b1);
      axi_read(reg_rx_errors, 32'd0, okay, 1'b1);
      end_test("3 frame counters", start);

      start      = errors;
      inject_err = 1'b1;
      send_frame(2, 5, 1'b1);
      wait_rx_drained();
      inject_err = 1'b0;
      axi_read(reg_rx_errors, 32'd1, okay, 1'b1);
      end_test("4 injected error", start);

      start = errors;
      axi_read(8'h14, 32'd0, slverr, 1'b0);
      axi_write(8'h14, 32'h1, slverr);
      axi_write(reg_tx_frames, 32'h5, slverr);
      axi_read(reg_tx_frames, 32'd21, okay, 1'b1);  // Read-only write had no effect
      axi_write(reg_ctrl, 32'h2, okay);
      axi_read(reg_ctrl, 32'h2, okay, 1'b1);
      axi_write(reg_ctrl, 32'h3, okay);
      axi_read(reg_ctrl, 32'h3, okay, 1'b1);
      end_test("5 register access", start);

      start = errors;
      axi_write(reg_ctrl, 32'h2, okay);          // Tx off while rx stays on
      check_idle     = 1'b1;
      tx_axis_tvalid = 1'b1;
      repeat (50) @(negedge clk156);
      tx_axis_tvalid = 1'b0;
      check_idle     = 1'b0;
      end_test("6 tx disabled", start);

      $display("tests passed: %0d, failed: %0d, errors: %0d", n_pass, n_fail, errors);
      if (n_fail == 0 && errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+tests
common/xgmac_pkg.sv
common/axil_pkg.sv
axi_ipif/axil_ipif_bridge.sv
xgmac/xgmac_regs.sv
xgmac/xgmac_tx.sv
xgmac/xgmac_rx.sv
source/axi_10g_mac.sv
tests/tb_axi_10g_mac.sv

//--- Makefile
TOP = tb_axi_10g_mac

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
